// ==== include/cpu6_defines.svh ====
`ifndef CPU6_DEFINES_SVH
`define CPU6_DEFINES_SVH

// data word width
`define CPU6_XLEN 32

// architectural registers, x0 included
`define CPU6_NREGS 32

// register index width
`define CPU6_RIDX_W 5

`endif

// ==== hw/cpu6_isa_pkg.sv ====
`include "cpu6_defines.svh"

package cpu6_isa_pkg;

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,  // register-register alu
      OPC_OP_IMM = 7'b0010011,  // register-immediate alu
      OPC_LUI    = 7'b0110111
   } cpu6_opcode_e;

   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'd0,
      F3_SLL     = 3'd1,
      F3_SLT     = 3'd2,
      F3_SLTU    = 3'd3,
      F3_XOR     = 3'd4,
      F3_SRL_SRA = 3'd5,
      F3_OR      = 3'd6,
      F3_AND     = 3'd7
   } cpu6_funct3_e;

   typedef struct packed {
      logic [6:0]              funct7;
      logic [`CPU6_RIDX_W-1:0] rs2;
      logic [`CPU6_RIDX_W-1:0] rs1;
      cpu6_funct3_e            funct3;
      logic [`CPU6_RIDX_W-1:0] rd;
      cpu6_opcode_e            opcode;
   } cpu6_r_t;

   typedef struct packed {
      logic [11:0]             imm;  // funct7 and shamt for shifts
      logic [`CPU6_RIDX_W-1:0] rs1;
      cpu6_funct3_e            funct3;
      logic [`CPU6_RIDX_W-1:0] rd;
      cpu6_opcode_e            opcode;
   } cpu6_i_t;

   typedef struct packed {
      logic [19:0]             imm;
      logic [`CPU6_RIDX_W-1:0] rd;
      cpu6_opcode_e            opcode;
   } cpu6_u_t;

   // one instruction word, three field layouts
   typedef union packed {
      cpu6_r_t r;
      cpu6_i_t i;
      cpu6_u_t u;
   } cpu6_instr_u;

endpackage

// ==== hw/cpu6_exu_pkg.sv ====
`include "cpu6_defines.svh"

package cpu6_exu_pkg;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10  // lui
   } cpu6_alu_op_e;

   typedef struct packed {
      cpu6_alu_op_e            alu_op;
      logic                    use_imm;  // operand b from imm
      logic [`CPU6_XLEN-1:0]   imm;
      logic [`CPU6_RIDX_W-1:0] rs1;
      logic [`CPU6_RIDX_W-1:0] rs2;
      logic [`CPU6_RIDX_W-1:0] rd;
      logic                    wr_en;
      logic                    illegal;
   } cpu6_dec_t;

   typedef struct packed {
      logic [`CPU6_RIDX_W-1:0] rd;
      logic [`CPU6_XLEN-1:0]   data;
      logic                    wr_en;
      logic                    illegal;
   } cpu6_result_t;

endpackage

// ==== hw/cpu6_decode.sv ====
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_decode
   import cpu6_isa_pkg::*;
   import cpu6_exu_pkg::*;
(
   input  cpu6_instr_u instr,
   output cpu6_dec_t   dec
);

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

   logic         alt;
   logic         f7_base;
   logic         f7_alt;
   cpu6_alu_op_e base_op;

   assign alt     = instr.r.funct7[5];
   assign f7_base = (instr.r.funct7 == F7_BASE);
   assign f7_alt  = (instr.r.funct7 == F7_ALT);

   // funct3 sits in the same bits for both r and i layouts
   always_comb begin
      case (instr.r.funct3)
         F3_ADD_SUB: base_op = ALU_ADD;
         F3_SLL:     base_op = ALU_SLL;
         F3_SLT:     base_op = ALU_SLT;
         F3_SLTU:    base_op = ALU_SLTU;
         F3_XOR:     base_op = ALU_XOR;
         F3_SRL_SRA: base_op = alt ? ALU_SRA : ALU_SRL;
         F3_OR:      base_op = ALU_OR;
         default:    base_op = ALU_AND;
      endcase
   end

   always_comb begin
      dec        = '0;
      dec.alu_op = base_op;
      case (instr.r.opcode)
         OPC_OP: begin
            dec.rs1 = instr.r.rs1;
            dec.rs2 = instr.r.rs2;
            dec.rd  = instr.r.rd;
            if (instr.r.funct3 == F3_ADD_SUB && alt)
               dec.alu_op = ALU_SUB;
            dec.illegal = !(f7_base || (f7_alt && (instr.r.funct3 == F3_ADD_SUB ||
                                                   instr.r.funct3 == F3_SRL_SRA)));
         end
         OPC_OP_IMM: begin
            dec.use_imm = 1'b1;
            dec.rs1     = instr.i.rs1;
            dec.rd      = instr.i.rd;
            dec.imm     = {{(`CPU6_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            // upper imm bits act as funct7 only for shifts
            if (instr.i.funct3 == F3_SLL)
               dec.illegal = !f7_base;
            else if (instr.i.funct3 == F3_SRL_SRA)
               dec.illegal = !(f7_base || f7_alt);
         end
         OPC_LUI: begin
            dec.alu_op  = ALU_PASS_B;
            dec.use_imm = 1'b1;
            dec.rd      = instr.u.rd;
            dec.imm     = {instr.u.imm, 12'b0};
         end
         default: begin
            dec.rd      = instr.r.rd;
            dec.illegal = 1'b1;
         end
      endcase
      dec.wr_en = !dec.illegal;
   end

endmodule

// ==== hw/cpu6_regfile.sv ====
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_regfile (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`CPU6_RIDX_W-1:0] rs1,
   input  logic [`CPU6_RIDX_W-1:0] rs2,
   output logic [`CPU6_XLEN-1:0]   rs1_data,
   output logic [`CPU6_XLEN-1:0]   rs2_data,
   input  logic                    wr,
   input  logic [`CPU6_RIDX_W-1:0] wr_rd,
   input  logic [`CPU6_XLEN-1:0]   wr_data
);

   // x0 has no storage
   logic [`CPU6_XLEN-1:0] regs [1:`CPU6_NREGS-1];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `CPU6_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr && wr_rd != '0) begin
         regs[wr_rd] <= wr_data;
      end
   end

   // reads are combinational, no bypass of the same-edge write
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/cpu6_shft.sv ====
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_shft (
   input  logic [`CPU6_XLEN-1:0] rs1_data,
   input  logic [`CPU6_XLEN-1:0] rs2_data,  // amount in [4:0]
   input  logic                  shft_lr,   // 0 left, 1 right
   input  logic                  shft_la,   // 0 logical, 1 arithmetic
   output logic [`CPU6_XLEN-1:0] shft_out
);

   logic [1:0]  shift16;  // one-hot 16/0
   logic [3:0]  shift4;   // one-hot 0/4/8/12
   logic [3:0]  shift1;   // one-hot 0/1/2/3
   logic [15:0] extendbit;

   logic [31:0] lshift16;
   logic [31:0] lshift4;
   logic [31:0] lshift1;
   logic [31:0] rshift16;
   logic [31:0] rshift4;
   logic [31:0] rshift1;

   assign extendbit = {16{shft_la & rs1_data[31]}};

   assign shift16[1] = rs2_data[4];
   assign shift16[0] = ~rs2_data[4];

   assign shift4[0] = ~rs2_data[3] & ~rs2_data[2];
   assign shift4[1] = ~rs2_data[3] &  rs2_data[2];
   assign shift4[2] =  rs2_data[3] & ~rs2_data[2];
   assign shift4[3] =  rs2_data[3] &  rs2_data[2];

   assign shift1[0] = ~rs2_data[1] & ~rs2_data[0];
   assign shift1[1] = ~rs2_data[1] &  rs2_data[0];
   assign shift1[2] =  rs2_data[1] & ~rs2_data[0];
   assign shift1[3] =  rs2_data[1] &  rs2_data[0];

   // right chain, vacated bits take extendbit
   assign rshift16 = ({32{shift16[1]}} & {extendbit, rs1_data[31:16]})
                   | ({32{shift16[0]}} & rs1_data[31:0]);

   assign rshift4 = ({32{shift4[3]}} & {extendbit[15:4], rshift16[31:12]})
                  | ({32{shift4[2]}} & {extendbit[15:8], rshift16[31:8]})
                  | ({32{shift4[1]}} & {extendbit[15:12], rshift16[31:4]})
                  | ({32{shift4[0]}} & rshift16);

   assign rshift1 = ({32{shift1[3]}} & {extendbit[15:13], rshift4[31:3]})
                  | ({32{shift1[2]}} & {extendbit[15:14], rshift4[31:2]})
                  | ({32{shift1[1]}} & {extendbit[15], rshift4[31:1]})
                  | ({32{shift1[0]}} & rshift4);

   // left chain, always zero fill
   assign lshift16 = ({32{shift16[1]}} & {rs1_data[15:0], 16'b0})
                   | ({32{shift16[0]}} & rs1_data[31:0]);

   assign lshift4 = ({32{shift4[3]}} & {lshift16[19:0], 12'b0})
                  | ({32{shift4[2]}} & {lshift16[23:0], 8'b0})
                  | ({32{shift4[1]}} & {lshift16[27:0], 4'b0})
                  | ({32{shift4[0]}} & lshift16);

   assign lshift1 = ({32{shift1[3]}} & {lshift4[28:0], 3'b0})
                  | ({32{shift1[2]}} & {lshift4[29:0], 2'b0})
                  | ({32{shift1[1]}} & {lshift4[30:0], 1'b0})
                  | ({32{shift1[0]}} & lshift4);

   assign shft_out = shft_lr ? rshift1 : lshift1;

endmodule

// ==== hw/cpu6_alu.sv ====
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_alu
   import cpu6_exu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  instr_vld,
   input  cpu6_dec_t             dec,
   input  logic [`CPU6_XLEN-1:0] rs1_data,
   input  logic [`CPU6_XLEN-1:0] rs2_data,
   output logic                  result_vld,
   output cpu6_result_t          result
);

   logic                  fwd_ok;
   logic [`CPU6_XLEN-1:0] op_a;
   logic [`CPU6_XLEN-1:0] src_b;
   logic [`CPU6_XLEN-1:0] op_b;
   logic                  shft_lr;
   logic                  shft_la;
   logic [`CPU6_XLEN-1:0] shft_out;
   logic [`CPU6_XLEN-1:0] alu_out;

   // result still in flight, the register file gets it at the next edge
   assign fwd_ok = result_vld && result.wr_en && (result.rd != '0);

   assign op_a  = (fwd_ok && result.rd == dec.rs1) ? result.data : rs1_data;
   assign src_b = (fwd_ok && result.rd == dec.rs2) ? result.data : rs2_data;
   assign op_b  = dec.use_imm ? dec.imm : src_b;

   assign shft_lr = (dec.alu_op == ALU_SRL) || (dec.alu_op == ALU_SRA);
   assign shft_la = (dec.alu_op == ALU_SRA);

   cpu6_shft u_shft (
      .rs1_data (op_a),
      .rs2_data (op_b),  // only [4:0] used
      .shft_lr  (shft_lr),
      .shft_la  (shft_la),
      .shft_out (shft_out)
   );

   always_comb begin
      case (dec.alu_op)
         ALU_ADD:    alu_out = op_a + op_b;
         ALU_SUB:    alu_out = op_a - op_b;
         ALU_SLT:    alu_out = {{(`CPU6_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         ALU_SLTU:   alu_out = {{(`CPU6_XLEN-1){1'b0}}, op_a < op_b};
         ALU_XOR:    alu_out = op_a ^ op_b;
         ALU_OR:     alu_out = op_a | op_b;
         ALU_AND:    alu_out = op_a & op_b;
         ALU_SLL,
         ALU_SRL,
         ALU_SRA:    alu_out = shft_out;
         ALU_PASS_B: alu_out = op_b;
         default:    alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         result_vld <= 1'b0;
         result     <= '0;
      end else begin
         result_vld <= instr_vld;
         if (instr_vld) begin
            result.rd      <= dec.rd;
            result.data    <= alu_out;
            result.wr_en   <= dec.wr_en;  // already low for illegal words
            result.illegal <= dec.illegal;
         end
      end
   end

endmodule

// ==== hw/cpu6_exu.sv ====
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_exu
   import cpu6_isa_pkg::*;
   import cpu6_exu_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         instr_vld,
   input  cpu6_instr_u  instr,
   output logic         result_vld,
   output cpu6_result_t result
);

   cpu6_dec_t             dec;
   logic [`CPU6_XLEN-1:0] rs1_data;
   logic [`CPU6_XLEN-1:0] rs2_data;

   cpu6_decode u_decode (
      .instr (instr),
      .dec   (dec)
   );

   // written back one edge after result_vld
   cpu6_regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .rs1      (dec.rs1),
      .rs2      (dec.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wr       (result_vld & result.wr_en),
      .wr_rd    (result.rd),
      .wr_data  (result.data)
   );

   cpu6_alu u_alu (
      .clk        (clk),
      .rst        (rst),
      .instr_vld  (instr_vld),
      .dec        (dec),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .result_vld (result_vld),
      .result     (result)
   );

endmodule

// ==== verif/cpu6_exu_tb.sv ====
`timescale 1ns/1ps
`include "cpu6_defines.svh"

module cpu6_exu_tb
   import cpu6_isa_pkg::*;
   import cpu6_exu_pkg::*;
();

   localparam int TIMEOUT = 50;  // cycles allowed for result_vld

   logic         clk;
   logic         rst;
   logic         instr_vld;
   cpu6_instr_u  instr;
   logic         result_vld;
   cpu6_result_t result;

   logic [`CPU6_XLEN-1:0] ref_regs [0:`CPU6_NREGS-1];  // expected register state
   cpu6_result_t          last;                        // result of the last single issue
   integer                seed = 32'ha2f7_d2fb;

   cpu6_exu u_cpu6_exu (
      .clk        (clk),
      .rst        (rst),
      .instr_vld  (instr_vld),
      .instr      (instr),
      .result_vld (result_vld),
      .result     (result)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [`CPU6_XLEN-1:0] rand_word();
      return $random(seed);
   endfunction

   // expected alu value from the operation rules
   function automatic logic [`CPU6_XLEN-1:0] model(cpu6_alu_op_e op,
                                                  logic [`CPU6_XLEN-1:0] a,
                                                  logic [`CPU6_XLEN-1:0] b);
      logic [4:0] sh;
      sh = b[4:0];  // shift amount is the low 5 bits only
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
         ALU_XOR:  return a ^ b;
         ALU_OR:   return a | b;
         ALU_AND:  return a & b;
         ALU_SLL:  return a << sh;
         ALU_SRL:  return a >> sh;
         ALU_SRA:  return $signed(a) >>> sh;  // fill with bit 31
         default:  return b;                  // lui
      endcase
   endfunction

   function automatic cpu6_funct3_e f3_of(cpu6_alu_op_e op);
      case (op)
         ALU_ADD, ALU_SUB: return F3_ADD_SUB;
         ALU_SLL:          return F3_SLL;
         ALU_SLT:          return F3_SLT;
         ALU_SLTU:         return F3_SLTU;
         ALU_XOR:          return F3_XOR;
         ALU_SRL, ALU_SRA: return F3_SRL_SRA;
         ALU_OR:           return F3_OR;
         default:          return F3_AND;
      endcase
   endfunction

   function automatic logic [6:0] f7_of(cpu6_alu_op_e op);
      return (op == ALU_SUB || op == ALU_SRA) ? 7'b0100000 : 7'b0000000;
   endfunction

   function automatic cpu6_instr_u r_instr(cpu6_alu_op_e op, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
      cpu6_instr_u w;
      w.r.funct7 = f7_of(op);
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3_of(op);
      w.r.rd     = rd;
      w.r.opcode = OPC_OP;
      return w;
   endfunction

   // shifts carry their funct7 in imm[11:5]
   function automatic cpu6_instr_u i_instr(cpu6_alu_op_e op, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
      cpu6_instr_u w;
      w.i.imm    = imm;
      w.i.rs1    = rs1;
      w.i.funct3 = f3_of(op);
      w.i.rd     = rd;
      w.i.opcode = OPC_OP_IMM;
      return w;
   endfunction

   function automatic cpu6_instr_u u_instr(logic [4:0] rd, logic [19:0] imm);
      cpu6_instr_u w;
      w.u.imm    = imm;
      w.u.rd     = rd;
      w.u.opcode = OPC_LUI;
      return w;
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_result(string name, cpu6_result_t exp, cpu6_result_t got);
      if (got !== exp)
         abort_run($sformatf({"Error %s: expected rd=%0d data=%h wr_en=%b illegal=%b,",
                              " actual rd=%0d data=%h wr_en=%b illegal=%b"},
                             name, exp.rd, exp.data, exp.wr_en, exp.illegal,
                             got.rd, got.data, got.wr_en, got.illegal));
   endtask

   task automatic check_word(string name, logic [`CPU6_XLEN-1:0] exp,
                             logic [`CPU6_XLEN-1:0] got);
      if (got !== exp)
         abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, got));
   endtask

   task automatic check_bit(string name, logic exp, logic got);
      if (got !== exp)
         abort_run($sformatf("Error %s: expected %b, actual %b", name, exp, got));
   endtask

   task automatic apply_reset();
      rst       = 1'b1;
      instr_vld = 1'b0;
      instr     = '0;
      for (int i = 0; i < `CPU6_NREGS; i++)
         ref_regs[i] = '0;
      repeat (16) begin
         @(negedge clk);
         check_bit("reset result_vld", 1'b0, result_vld);
      end
      rst = 1'b0;
   endtask

   // one instruction alone, result taken at the falling edge
   task automatic issue(string name, cpu6_instr_u w);
      int n;
      @(negedge clk);
      instr     = w;
      instr_vld = 1'b1;
      @(negedge clk);
      instr_vld = 1'b0;
      n = 0;
      while (result_vld !== 1'b1 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (result_vld !== 1'b1)
         abort_run($sformatf("%s: result_vld never came", name));
      last = result;
   endtask

   task automatic exec(string name, cpu6_instr_u w, cpu6_alu_op_e op, logic [4:0] rd,
                       logic [`CPU6_XLEN-1:0] a, logic [`CPU6_XLEN-1:0] b);
      cpu6_result_t exp;
      exp.rd      = rd;
      exp.data    = model(op, a, b);
      exp.wr_en   = 1'b1;
      exp.illegal = 1'b0;
      issue(name, w);
      check_result(name, exp, last);
      if (rd != 5'd0)
         ref_regs[rd] = exp.data;
   endtask

   task automatic alu_reg(string name, cpu6_alu_op_e op, logic [4:0] rd,
                          logic [4:0] rs1, logic [4:0] rs2);
      exec(name, r_instr(op, rd, rs1, rs2), op, rd, ref_regs[rs1], ref_regs[rs2]);
   endtask

   task automatic alu_imm(string name, cpu6_alu_op_e op, logic [4:0] rd,
                          logic [4:0] rs1, logic [11:0] imm);
      exec(name, i_instr(op, rd, rs1, imm), op, rd, ref_regs[rs1], {{20{imm[11]}}, imm});
   endtask

   task automatic load_upper(string name, logic [4:0] rd, logic [19:0] imm);
      exec(name, u_instr(rd, imm), ALU_PASS_B, rd, 32'd0, {imm, 12'b0});
   endtask

   task automatic load_reg(logic [4:0] rd, logic [`CPU6_XLEN-1:0] val);
      logic [19:0] hi;
      hi = val[31:12] + {19'b0, val[11]};  // addi sign-extends the low part
      load_upper("load lui", rd, hi);
      alu_imm("load addi", ALU_ADD, rd, rd, val[11:0]);
   endtask

   // or with x0 copies a register into x20
   task automatic read_reg(string name, logic [4:0] rs, logic [`CPU6_XLEN-1:0] exp);
      issue(name, r_instr(ALU_OR, 5'd20, rs, 5'd0));
      check_word(name, exp, last.data);
      ref_regs[20] = exp;
   endtask

   task automatic reset_behavior();
      alu_reg("reset_state", ALU_ADD, 5'd3, 5'd1, 5'd2);
   endtask

   task automatic immediate_ops();
      for (int k = 0; k < 8; k++) begin
         load_reg(5'd1, rand_word());
         alu_imm("addi", ALU_ADD, 5'd5, 5'd1, 12'(rand_word()));
         alu_imm("xori", ALU_XOR, 5'd6, 5'd5, 12'(rand_word()));
         alu_imm("ori", ALU_OR, 5'd7, 5'd6, 12'(rand_word()));
         alu_imm("andi", ALU_AND, 5'd8, 5'd1, 12'(rand_word()));
         alu_imm("slti", ALU_SLT, 5'd9, 5'd1, 12'(rand_word()));
         alu_imm("sltiu", ALU_SLTU, 5'd10, 5'd1, 12'(rand_word()));
         load_upper("lui", 5'd11, 20'(rand_word()));
         for (int r = 5; r <= 11; r++) begin
            read_reg("imm readback", 5'(r), ref_regs[r]);
         end
      end
   endtask

   task automatic reg_sweep();
      alu_reg("add", ALU_ADD, 5'd3, 5'd1, 5'd2);
      alu_reg("sub", ALU_SUB, 5'd4, 5'd1, 5'd2);
      alu_reg("xor", ALU_XOR, 5'd5, 5'd1, 5'd2);
      alu_reg("or", ALU_OR, 5'd6, 5'd1, 5'd2);
      alu_reg("and", ALU_AND, 5'd7, 5'd1, 5'd2);
      alu_reg("slt", ALU_SLT, 5'd8, 5'd1, 5'd2);
      alu_reg("sltu", ALU_SLTU, 5'd9, 5'd1, 5'd2);
   endtask

   task automatic register_ops();
      for (int k = 0; k < 8; k++) begin
         load_reg(5'd1, rand_word());
         load_reg(5'd2, rand_word());
         reg_sweep();
      end
      // negative vs positive, signed and unsigned order disagree
      load_reg(5'd1, 32'h8000_0010);
      load_reg(5'd2, 32'h0000_0020);
      reg_sweep();
      load_reg(5'd1, 32'h0000_0020);
      load_reg(5'd2, 32'h8000_0010);
      reg_sweep();
   endtask

   task automatic shift_sweep();
      logic [`CPU6_XLEN-1:0] val;
      for (int amt = 0; amt < 32; amt++) begin
         for (int s = 0; s < 2; s++) begin
            val = rand_word();
            val[31] = s[0];
            load_reg(5'd1, val);
            alu_imm("slli", ALU_SLL, 5'd3, 5'd1, {7'b0000000, 5'(amt)});
            alu_imm("srli", ALU_SRL, 5'd4, 5'd1, {7'b0000000, 5'(amt)});
            alu_imm("srai", ALU_SRA, 5'd5, 5'd1, {7'b0100000, 5'(amt)});
            load_reg(5'd2, {27'(rand_word()), 5'(amt)});  // junk above the amount
            alu_reg("sll", ALU_SLL, 5'd6, 5'd1, 5'd2);
            alu_reg("srl", ALU_SRL, 5'd7, 5'd1, 5'd2);
            alu_reg("sra", ALU_SRA, 5'd8, 5'd1, 5'd2);
         end
      end
   endtask

   task automatic dependent_chain();
      cpu6_instr_u  w [10];
      cpu6_result_t exp [10];
      logic [4:0]   prev;
      logic [4:0]   rd;
      logic [11:0]  imm;
      load_reg(5'd1, rand_word());
      prev = 5'd1;
      for (int i = 0; i < 8; i++) begin
         rd  = 5'(10 + i);
         imm = 12'(rand_word());
         exp[i].rd      = rd;
         exp[i].wr_en   = 1'b1;
         exp[i].illegal = 1'b0;
         case (i % 4)
            0: begin
               w[i] = i_instr(ALU_ADD, rd, prev, imm);
               exp[i].data = model(ALU_ADD, ref_regs[prev], {{20{imm[11]}}, imm});
            end
            1: begin  // dependence through rs2
               w[i] = r_instr(ALU_SUB, rd, 5'd1, prev);
               exp[i].data = model(ALU_SUB, ref_regs[1], ref_regs[prev]);
            end
            2: begin
               w[i] = r_instr(ALU_XOR, rd, prev, 5'd1);
               exp[i].data = model(ALU_XOR, ref_regs[prev], ref_regs[1]);
            end
            default: begin
               w[i] = i_instr(ALU_SRA, rd, prev, {7'b0100000, imm[4:0]});
               exp[i].data = model(ALU_SRA, ref_regs[prev], {27'b0, imm[4:0]});
            end
         endcase
         ref_regs[rd] = exp[i].data;
         prev = rd;
      end
      // x0 write, then x0 read while that write is still in flight
      w[8]           = i_instr(ALU_ADD, 5'd0, prev, 12'h123);
      exp[8].rd      = 5'd0;
      exp[8].data    = model(ALU_ADD, ref_regs[prev], 32'h123);
      exp[8].wr_en   = 1'b1;
      exp[8].illegal = 1'b0;
      w[9]           = r_instr(ALU_ADD, 5'd7, 5'd0, 5'd0);
      exp[9].rd      = 5'd7;
      exp[9].data    = 32'd0;  // x0 always reads zero
      exp[9].wr_en   = 1'b1;
      exp[9].illegal = 1'b0;
      ref_regs[7]    = 32'd0;
      @(negedge clk);
      instr     = w[0];
      instr_vld = 1'b1;
      for (int i = 1; i <= 10; i++) begin
         @(negedge clk);
         if (result_vld !== 1'b1)
            abort_run("chain: result_vld missing one cycle after a back-to-back issue");
         check_result("chain", exp[i-1], result);
         if (i < 10)
            instr = w[i];
         else
            instr_vld = 1'b0;
      end
   endtask

   task automatic illegal_check(string name, cpu6_instr_u w);
      issue(name, w);
      check_bit({name, " illegal"}, 1'b1, last.illegal);
      check_bit({name, " wr_en"}, 1'b0, last.wr_en);
   endtask

   task automatic illegal_words();
      cpu6_instr_u           w;
      logic [`CPU6_XLEN-1:0] keep;
      load_reg(5'd9, rand_word());
      keep = ref_regs[9];
      w = r_instr(ALU_ADD, 5'd9, 5'd1, 5'd2);
      w = {w[31:7], 7'b1111111};  // no such opcode here
      illegal_check("bad opcode", w);
      w = r_instr(ALU_ADD, 5'd9, 5'd1, 5'd2);
      w.r.funct7 = 7'b0000001;    // mul encoding
      illegal_check("bad funct7", w);
      w = i_instr(ALU_SRA, 5'd9, 5'd1, {7'b0100001, 5'd3});
      illegal_check("bad srai funct7", w);
      read_reg("illegal readback", 5'd9, keep);
   endtask

   initial begin
      apply_reset();
      reset_behavior();
      immediate_ops();
      register_ops();
      shift_sweep();
      dependent_chain();
      illegal_words();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+include
hw/cpu6_isa_pkg.sv
hw/cpu6_exu_pkg.sv
hw/cpu6_decode.sv
hw/cpu6_regfile.sv
hw/cpu6_shft.sv
hw/cpu6_alu.sv
hw/cpu6_exu.sv
verif/cpu6_exu_tb.sv

// ==== Makefile ====
# Verilator build of the cpu6 execute unit testbench

SIM := obj_dir/Vcpu6_exu_tb

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): compile.f $(wildcard hw/*.sv verif/*.sv include/*.svh)
	verilator --binary --timing -j 0 --top-module cpu6_exu_tb -f compile.f

# exit status of the binary is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
